// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= exec_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '*** FAILED ***' $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== logic/exec_pipe.sv ====
`default_nettype none

module exec_pipe (
  input  logic               clk,
  input  logic               reset,
  input  logic               in_valid,
  input  pipe_pkg::inst_t    in_inst,
  input  logic               forward_sel_1,
  input  logic               forward_sel_2,
  input  logic               stall,
  input  logic               flush,
  input  pipe_pkg::word_t    product,
  input  logic               mul_done,
  output pipe_pkg::inst_t    inst_exec,
  output pipe_pkg::inst_t    inst_mem,
  output logic               reg_wr,
  output logic               mem_read,
  output logic               branch_taken,
  output logic               mul_start,
  output pipe_pkg::word_t    mul_a,
  output pipe_pkg::word_t    mul_b,
  output logic               out_valid,
  output pipe_pkg::reg_idx_t out_rd,
  output pipe_pkg::word_t    out_result
);
  import pipe_pkg::*;

  word_t      regs [32];
  word_t      dmem [dmem_words];
  logic [6:0] ex_op;
  logic [2:0] ex_f3;
  logic [6:0] ex_f7;
  reg_idx_t   ex_rs1;
  reg_idx_t   ex_rs2;
  word_t      imm_i;
  word_t      imm_s;
  word_t      rf_a;
  word_t      rf_b;
  word_t      op_a;
  word_t      op_b;
  word_t      alu_b;
  word_t      alu_res;
  word_t      ex_result;
  logic       mul_issued;
  logic [6:0] mem_op;
  logic       mem_first;
  logic       load_hold;
  word_t      mem_result;
  word_t      mem_wdata;
  word_t      wb_data;

  // execute stage decode
  assign ex_op  = inst_exec[6:0];
  assign ex_f3  = inst_exec[14:12];
  assign ex_f7  = inst_exec[31:25];
  assign ex_rs1 = inst_exec[19:15];
  assign ex_rs2 = inst_exec[24:20];
  assign imm_i  = {{20{inst_exec[31]}}, inst_exec[31:20]};
  assign imm_s  = {{20{inst_exec[31]}}, inst_exec[31:25], inst_exec[11:7]};

  // register read, write-through from the retiring instruction
  assign rf_a = (ex_rs1 == '0) ? '0 :
                (out_valid && out_rd == ex_rs1) ? wb_data : regs[ex_rs1];
  assign rf_b = (ex_rs2 == '0) ? '0 :
                (out_valid && out_rd == ex_rs2) ? wb_data : regs[ex_rs2];

  assign op_a  = forward_sel_1 ? mem_result : rf_a;
  assign op_b  = forward_sel_2 ? mem_result : rf_b;
  assign alu_b = (ex_op == op_r) ? op_b : imm_i;

  always_comb begin
    case (ex_f3)
      f3_add:  alu_res = (ex_op == op_r && ex_f7 == funct7_sub) ? op_a - alu_b : op_a + alu_b;
      f3_and:  alu_res = op_a & alu_b;
      f3_or:   alu_res = op_a | alu_b;
      f3_xor:  alu_res = op_a ^ alu_b;
      default: alu_res = op_a + alu_b;
    endcase
  end

  always_comb begin
    if (mul_done) begin
      ex_result = product;
    end else if (ex_op == op_load) begin
      ex_result = op_a + imm_i;
    end else if (ex_op == op_store) begin
      ex_result = op_a + imm_s;
    end else begin
      ex_result = alu_res;
    end
  end

  assign branch_taken = (ex_op == op_branch) && (op_a == op_b);

  // start once per MUL, after any load ahead of it has written back
  assign mul_start = (ex_op == op_r) && (ex_f7 == funct7_mul) && (ex_f3 == f3_add) &&
                     !mul_issued && !load_hold;
  assign mul_a     = op_a;
  assign mul_b     = op_b;

  // mem stage decode
  assign mem_op    = inst_mem[6:0];
  assign mem_read  = (mem_op == op_load);
  assign reg_wr    = (mem_op == op_r) || (mem_op == op_imm) || (mem_op == op_load);
  assign load_hold = mem_read & reg_wr & mem_first;
  assign wb_data   = mem_read ? dmem[mem_result[dmem_aw+1:2]] : mem_result;

  assign out_valid  = reg_wr & ~load_hold;
  assign out_rd     = inst_mem[11:7];
  assign out_result = wb_data;

  // stage control
  always_ff @(posedge clk) begin
    if (reset) begin
      inst_exec  <= '0;
      inst_mem   <= '0;
      mul_issued <= 1'b0;
      mem_first  <= 1'b0;
    end else begin
      mem_first <= ~stall;
      if (!stall) begin
        inst_exec  <= (in_valid && !flush) ? in_inst : '0;
        inst_mem   <= inst_exec;
        mul_issued <= 1'b0;
      end else begin
        if (mul_start) begin
          mul_issued <= 1'b1;
        end
        // mem stage keeps only a load in its first cycle
        if (!load_hold) begin
          inst_mem <= '0;
        end
      end
    end
  end

  // mem stage payload
  always_ff @(posedge clk) begin
    if (!stall) begin
      mem_result <= ex_result;
      mem_wdata  <= op_b;
    end
  end

  // register file and scratch memory
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
      for (int i = 0; i < dmem_words; i++) begin
        dmem[i] <= '0;
      end
    end else begin
      if (out_valid && out_rd != '0) begin
        regs[out_rd] <= wb_data;
      end
      if (mem_op == op_store) begin
        dmem[mem_result[dmem_aw+1:2]] <= mem_wdata;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/exec_top.sv ====
`default_nettype none

module exec_top (
  input  logic               clk,
  input  logic               reset,
  input  logic               in_valid,
  input  logic               irq,
  input  pipe_pkg::inst_t    in_inst,
  output logic               stall,
  output logic               out_valid,
  output pipe_pkg::reg_idx_t out_rd,
  output pipe_pkg::word_t    out_result
);
  import pipe_pkg::*;

  inst_t inst_exec;
  inst_t inst_mem;
  logic  reg_wr;
  logic  mem_read;
  logic  branch_taken;
  logic  forward_sel_1;
  logic  forward_sel_2;
  logic  flush;
  logic  mul_start;
  word_t mul_a;
  word_t mul_b;
  word_t product;
  logic  m_busy;
  logic  m_done;

  hazard_unit hazard_i (
    .clk           (clk),
    .reset         (reset),
    .reg_wr        (reg_wr),
    .mem_read      (mem_read),
    .branch_taken  (branch_taken),
    .irq           (irq),
    .inst_exec     (inst_exec),
    .inst_mem      (inst_mem),
    .m_busy        (m_busy),
    .m_done        (m_done),
    .forward_sel_1 (forward_sel_1),
    .forward_sel_2 (forward_sel_2),
    .flush         (flush),
    .stall         (stall)
  );

  mul_unit mul_i (
    .clk     (clk),
    .reset   (reset),
    .start   (mul_start),
    .a       (mul_a),
    .b       (mul_b),
    .busy    (m_busy),
    .done    (m_done),
    .product (product)
  );

  exec_pipe pipe_i (
    .clk           (clk),
    .reset         (reset),
    .in_valid      (in_valid),
    .in_inst       (in_inst),
    .forward_sel_1 (forward_sel_1),
    .forward_sel_2 (forward_sel_2),
    .stall         (stall),
    .flush         (flush),
    .product       (product),
    .mul_done      (m_done),
    .inst_exec     (inst_exec),
    .inst_mem      (inst_mem),
    .reg_wr        (reg_wr),
    .mem_read      (mem_read),
    .branch_taken  (branch_taken),
    .mul_start     (mul_start),
    .mul_a         (mul_a),
    .mul_b         (mul_b),
    .out_valid     (out_valid),
    .out_rd        (out_rd),
    .out_result    (out_result)
  );

endmodule

`default_nettype wire

// ==== logic/hazard_unit.sv ====
`default_nettype none

module hazard_unit (
  input  logic            clk,
  input  logic            reset,
  input  logic            reg_wr,
  input  logic            mem_read,
  input  logic            branch_taken,
  input  logic            irq,
  input  pipe_pkg::inst_t inst_exec,
  input  pipe_pkg::inst_t inst_mem,
  input  logic            m_busy,
  input  logic            m_done,
  output logic            forward_sel_1,
  output logic            forward_sel_2,
  output logic            flush,
  output logic            stall
);
  import pipe_pkg::*;

  reg_idx_t  rs1_exec;
  reg_idx_t  rs2_exec;
  reg_idx_t  rd_mem;
  hz_state_t state;
  hz_state_t state_next;
  logic      stall_load;
  logic      stall_mul;

  assign rs1_exec = inst_exec[19:15];
  assign rs2_exec = inst_exec[24:20];
  assign rd_mem   = inst_mem[11:7];

  // forward a mem-stage ALU result, never a load and never x0
  always_comb begin
    forward_sel_1 = 1'b0;
    forward_sel_2 = 1'b0;
    if (reg_wr && !mem_read && rd_mem != '0) begin
      if (rs1_exec == rd_mem) begin
        forward_sel_1 = 1'b1;
      end
      if (rs2_exec == rd_mem) begin
        forward_sel_2 = 1'b1;
      end
    end
  end

  // one hold cycle for a load sitting in the mem stage
  always_comb begin
    stall_load = 1'b0;
    state_next = state;
    case (state)
      normal: begin
        if (mem_read && reg_wr) begin
          stall_load = 1'b1;
          state_next = stalled;
        end
      end
      stalled: begin
        state_next = normal;
      end
      default: begin
        state_next = normal;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= normal;
    end else begin
      state <= state_next;
    end
  end

  // multiplier holds the pipe until its done pulse
  assign stall_mul = m_busy & ~m_done;

  assign stall = stall_load | stall_mul;

  // incoming instruction is dropped on a taken branch or irq
  assign flush = branch_taken | irq;

endmodule

`default_nettype wire

// ==== logic/mul_unit.sv ====
`default_nettype none

module mul_unit (
  input  logic            clk,
  input  logic            reset,
  input  logic            start,
  input  pipe_pkg::word_t a,
  input  pipe_pkg::word_t b,
  output logic            busy,
  output logic            done,
  output pipe_pkg::word_t product
);
  import pipe_pkg::*;

  mul_state_t state;
  logic [4:0] count;
  word_t      acc;
  word_t      mcand;
  word_t      mplier;

  // busy covers the start cycle so the stall begins at once
  assign busy    = (state == run) | start;
  assign product = acc;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      count <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        idle: begin
          if (start) begin
            state <= run;
            count <= 5'd1;
          end
        end
        run: begin
          count <= count + 5'd1;
          // bit 31 handled at this edge
          if (count == 5'd31) begin
            state <= idle;
            done  <= 1'b1;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // shift-add datapath, bit 0 of b is consumed on the start edge
  always_ff @(posedge clk) begin
    if (state == idle && start) begin
      acc    <= b[0] ? a : '0;
      mcand  <= a << 1;
      mplier <= b >> 1;
    end else if (state == run) begin
      acc    <= acc + (mplier[0] ? mcand : '0);
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

endmodule

`default_nettype wire

// ==== logic/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

  // data and instruction words
  typedef logic [31:0] word_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;

  // RV32 opcodes
  localparam logic [6:0] op_r      = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;

  // R-type funct7
  localparam logic [6:0] funct7_mul = 7'b0000001;
  localparam logic [6:0] funct7_sub = 7'b0100000;

  // funct3 for the ALU ops
  localparam logic [2:0] f3_add = 3'b000;
  localparam logic [2:0] f3_and = 3'b111;
  localparam logic [2:0] f3_or  = 3'b110;
  localparam logic [2:0] f3_xor = 3'b100;

  // scratch memory, word addressed by byte address bits 5..2
  localparam int dmem_words = 16;
  localparam int dmem_aw    = $clog2(dmem_words);

  // load stall FSM
  typedef enum logic {
    normal,
    stalled
  } hz_state_t;

  // multiplier FSM
  typedef enum logic {
    idle,
    run
  } mul_state_t;

endpackage

`default_nettype wire

// ==== testbench/exec_asserts.sv ====
`default_nettype none

module exec_asserts (
  input logic clk,
  input logic reset,
  input logic in_valid,
  input logic stall,
  input logic out_valid,
  input logic mem_read,
  input logic forward_sel_1,
  input logic forward_sel_2
);

  // both stages hold bubbles right after reset
  quiet_after_reset: assert property (
    @(posedge clk) reset |=> (!stall && !out_valid)
  ) else $error("stall or out_valid high after reset");

  // source must hold off while the pipe is stalled
  no_issue_in_stall: assert property (
    @(posedge clk) disable iff (reset) !(in_valid && stall)
  ) else $error("in_valid high while stall is high");

  // a load result is never forwarded
  no_load_forward: assert property (
    @(posedge clk) disable iff (reset) mem_read |-> !(forward_sel_1 || forward_sel_2)
  ) else $error("forward select high with a load in the mem stage");

endmodule

bind exec_top exec_asserts asserts_i (
  .clk           (clk),
  .reset         (reset),
  .in_valid      (in_valid),
  .stall         (stall),
  .out_valid     (out_valid),
  .mem_read      (mem_read),
  .forward_sel_1 (forward_sel_1),
  .forward_sel_2 (forward_sel_2)
);

`default_nettype wire

// ==== testbench/exec_tb.sv ====
`default_nettype none

module exec_tb;
  import pipe_pkg::*;

  localparam int period       = 40;
  localparam int n_insts      = 400;
  localparam int stall_limit  = 100;
  localparam int retire_limit = 200;
  localparam int drain_limit  = 500;

  logic     clk;
  logic     reset;
  logic     in_valid;
  logic     irq;
  inst_t    in_inst;
  logic     stall;
  logic     out_valid;
  reg_idx_t out_rd;
  word_t    out_result;

  integer   seed = 12;
  int       idle_cycles = 0;
  word_t    regs_m [32];
  word_t    mem_m [dmem_words];
  reg_idx_t exp_rd [$];
  word_t    exp_result [$];

  exec_top dut_i (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .irq        (irq),
    .in_inst    (in_inst),
    .stall      (stall),
    .out_valid  (out_valid),
    .out_rd     (out_rd),
    .out_result (out_result)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_rd(input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch at time %0t: out_rd is %0d, expected %0d",
                               $time, got, exp));
    end
  endtask

  task automatic check_result(input word_t got, input word_t exp);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch at time %0t: out_result is %h, expected %h",
                               $time, got, exp));
    end
  endtask

  // x1..x7 keep hazards frequent and x0 shows up now and then
  function automatic reg_idx_t pick_reg();
    logic [31:0] r;
    r = $random(seed);
    if (r[3:0] == 4'd0) begin
      return '0;
    end
    return reg_idx_t'(32'd1 + ((r >> 4) % 32'd7));
  endfunction

  function automatic inst_t make_inst();
    logic [31:0] r;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [11:0] off;
    inst_t       inst;
    r   = $random(seed);
    rd  = pick_reg();
    rs1 = pick_reg();
    rs2 = pick_reg();
    // word offsets 0..60 keep loads and stores on the 16 words
    off = {6'b0, r[19:16], 2'b00};
    case (r % 32'd10)
      0: inst = {7'b0, rs2, rs1, f3_add, rd, op_r};
      1: inst = {funct7_sub, rs2, rs1, f3_add, rd, op_r};
      2: inst = {7'b0, rs2, rs1, f3_and, rd, op_r};
      3: inst = {7'b0, rs2, rs1, f3_or, rd, op_r};
      4: inst = {7'b0, rs2, rs1, f3_xor, rd, op_r};
      5: inst = {funct7_mul, rs2, rs1, f3_add, rd, op_r};
      6: inst = {r[31:20], rs1, f3_add, rd, op_imm};
      7: inst = {off, rs1, 3'b010, rd, op_load};
      8: inst = {off[11:5], rs2, rs1, 3'b010, off[4:0], op_store};
      default: inst = {7'b0, rs2, rs1, 3'b000, 5'b0, op_branch};
    endcase
    return inst;
  endfunction

  task automatic push_retire(input reg_idx_t rd, input word_t res);
    exp_rd.push_back(rd);
    exp_result.push_back(res);
    // x0 retires its value but keeps reading zero
    if (rd != '0) begin
      regs_m[rd] = res;
    end
  endtask

  // ISA level model applying one instruction in program order
  task automatic apply_model(input inst_t inst, output logic taken);
    logic [6:0] op;
    logic [6:0] f7;
    logic [2:0] f3;
    reg_idx_t   rd;
    word_t      a;
    word_t      b;
    word_t      res;
    word_t      addr;
    op    = inst[6:0];
    f7    = inst[31:25];
    f3    = inst[14:12];
    rd    = inst[11:7];
    a     = regs_m[inst[19:15]];
    b     = regs_m[inst[24:20]];
    taken = 1'b0;
    case (op)
      op_r: begin
        if (f7 == funct7_mul) begin
          res = a * b;
        end else if (f7 == funct7_sub) begin
          res = a - b;
        end else begin
          case (f3)
            f3_and:  res = a & b;
            f3_or:   res = a | b;
            f3_xor:  res = a ^ b;
            default: res = a + b;
          endcase
        end
        push_retire(rd, res);
      end
      op_imm: begin
        push_retire(rd, a + {{20{inst[31]}}, inst[31:20]});
      end
      op_load: begin
        addr = a + {{20{inst[31]}}, inst[31:20]};
        push_retire(rd, mem_m[addr[5:2]]);
      end
      op_store: begin
        addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
        mem_m[addr[5:2]] = b;
      end
      op_branch: begin
        taken = (a == b);
      end
      default: begin
        taken = 1'b0;
      end
    endcase
  endtask

  // called on a falling edge and returns on the next one
  task automatic issue_inst(input inst_t inst, input logic irq_bit);
    int waits;
    waits = 0;
    while (stall && waits < stall_limit) begin
      in_valid = 1'b0;
      irq      = 1'b0;
      @(negedge clk);
      waits++;
    end
    if (stall) begin
      report_failure("stall stayed high too long, no issue slot came");
    end else begin
      in_valid = 1'b1;
      in_inst  = inst;
      irq      = irq_bit;
      @(negedge clk);
    end
  endtask

  // retirement checker
  always @(negedge clk) begin
    if (!reset) begin
      if (out_valid) begin
        idle_cycles = 0;
        if (exp_rd.size() == 0) begin
          report_failure("out_valid went high with no retirement expected");
        end else begin
          check_rd(out_rd, exp_rd.pop_front());
          check_result(out_result, exp_result.pop_front());
        end
      end else if (exp_rd.size() != 0) begin
        idle_cycles++;
        if (idle_cycles > retire_limit) begin
          report_failure("timeout while waiting for out_valid");
        end
      end
    end
  end

  initial begin
    inst_t inst;
    logic  irq_bit;
    logic  skip_next;
    logic  taken;
    int    waits;
    reset     = 1'b1;
    in_valid  = 1'b0;
    irq       = 1'b0;
    in_inst   = '0;
    skip_next = 1'b0;
    for (int i = 0; i < 32; i++) begin
      regs_m[i] = '0;
    end
    for (int i = 0; i < dmem_words; i++) begin
      mem_m[i] = '0;
    end
    repeat (5) @(negedge clk);
    reset = 1'b0;

    for (int n = 0; n < n_insts; n++) begin
      inst    = make_inst();
      irq_bit = (($random(seed) & 32'd31) == 32'd0);
      // the slot after a taken BEQ and an irq slot are both dropped
      if (irq_bit || skip_next) begin
        skip_next = 1'b0;
      end else begin
        apply_model(inst, taken);
        skip_next = taken;
      end
      issue_inst(inst, irq_bit);
    end
    in_valid = 1'b0;
    irq      = 1'b0;

    waits = 0;
    while (exp_rd.size() != 0 && waits < drain_limit) begin
      @(negedge clk);
      waits++;
    end
    if (exp_rd.size() != 0) begin
      report_failure("retirements still missing at the end of the run");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/pipe_pkg.sv
logic/hazard_unit.sv
logic/mul_unit.sv
logic/exec_pipe.sv
logic/exec_top.sv
testbench/exec_asserts.sv
testbench/exec_tb.sv
